/* hw/ooo_pkg.sv */
// Out-of-order core shared definitions
package ooo_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int XLEN      = 32;
  localparam int NUM_PREGS = 32;
  localparam int PREG_W    = 5;
  localparam int IQ_DEPTH  = 4;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [PREG_W-1:0] preg_t;

  // ------------------------------
  // Operation encodings
  // ------------------------------

  // Picks the issue queue
  typedef enum logic {
    CLASS_ALU = 1'b0,
    CLASS_CMP = 1'b1
  } op_class_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_XOR = 2'b11
  } alu_op_t;

  // Compare result is written as 1 or 0
  typedef enum logic [1:0] {
    CMP_EQ  = 2'b00,
    CMP_NE  = 2'b01,
    CMP_LT  = 2'b10,
    CMP_LTU = 2'b11
  } cmp_cond_t;

  // ------------------------------
  // Packets
  // ------------------------------

  // Renamed operation at dispatch, 18 bits
  typedef struct packed {
    op_class_t  op_class;
    logic [1:0] func;
    preg_t      prs1;
    preg_t      prs2;
    preg_t      prd;
  } disp_op_t;

  // Register part of a queue entry, 17 bits
  typedef struct packed {
    preg_t prs1;
    preg_t prs2;
    preg_t prd;
    logic  rdy1;
    logic  rdy2;
  } src_tags_t;

  // Writeback broadcast, 38 bits
  typedef struct packed {
    logic  valid;
    preg_t preg;
    xlen_t value;
  } wb_t;

endpackage

/* hw/issue_queue.sv */
// Issue queue with operand wakeup
`timescale 1ns/1ps

module issue_queue #(
  parameter int  DEPTH     = ooo_pkg::IQ_DEPTH,
  parameter type payload_t = logic [1:0]
) (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               insert_valid_i,
  input  payload_t           insert_payload_i,
  input  ooo_pkg::src_tags_t insert_tags_i,
  output logic               full_o,

  input  ooo_pkg::wb_t       wb_i,

  output logic               req_valid_o,
  output payload_t           req_payload_o,
  output ooo_pkg::src_tags_t req_tags_o,
  input  logic               grant_i
);

  import ooo_pkg::*;

  typedef logic [$clog2(DEPTH)-1:0] idx_t;

  logic [DEPTH-1:0] valid_q;
  payload_t         payload_q [DEPTH];
  src_tags_t        tags_q    [DEPTH];

  logic [DEPTH-1:0] ready_vec;
  idx_t             free_idx;
  idx_t             sel_idx;
  logic             do_insert;

  // ------------------------------
  // Slot selection
  // ------------------------------

  // Entry may issue once both sources are ready
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready_vec[i] = valid_q[i] && tags_q[i].rdy1 && tags_q[i].rdy2;
    end
  end

  // Walk downwards so the lowest index wins
  always_comb begin
    free_idx = '0;
    sel_idx  = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = idx_t'(i);
      end
      if (ready_vec[i]) begin
        sel_idx = idx_t'(i);
      end
    end
  end

  assign full_o        = &valid_q;
  assign do_insert     = insert_valid_i && !full_o;
  assign req_valid_o   = |ready_vec;
  assign req_payload_o = payload_q[sel_idx];
  assign req_tags_o    = tags_q[sel_idx];

  // ------------------------------
  // Storage
  // ------------------------------

  // Free slot never coincides with the granted one
  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= '0;
    end else begin
      if (grant_i) begin
        valid_q[sel_idx] <= 1'b0;
      end
      if (do_insert) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  // Wakeup on tag match with the writeback
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wb_i.valid && valid_q[i]) begin
        if (tags_q[i].prs1 == wb_i.preg) begin
          tags_q[i].rdy1 <= 1'b1;
        end
        if (tags_q[i].prs2 == wb_i.preg) begin
          tags_q[i].rdy2 <= 1'b1;
        end
      end
    end
    if (do_insert) begin
      payload_q[free_idx] <= insert_payload_i;
      tags_q[free_idx]    <= insert_tags_i;
    end
  end

  // Dispatch must hold off while this queue is full
  a_no_insert_when_full: assert property (
    @(posedge clk) disable iff (rst_n) insert_valid_i |-> !full_o
  );

endmodule

/* hw/dispatch_unit.sv */
// Dispatch steering and readiness
`timescale 1ns/1ps

module dispatch_unit (
  input  logic                          disp_valid_i,
  input  ooo_pkg::disp_op_t             disp_op_i,
  output logic                          disp_ready_o,

  input  logic                          alu_full_i,
  input  logic                          cmp_full_i,

  input  logic [ooo_pkg::NUM_PREGS-1:0] prf_valid_i,
  input  ooo_pkg::wb_t                  wb_i,

  output logic                          alu_insert_o,
  output logic                          cmp_insert_o,
  output ooo_pkg::alu_op_t              alu_func_o,
  output ooo_pkg::cmp_cond_t            cmp_func_o,
  output ooo_pkg::src_tags_t            tags_o,

  output logic                          inval_valid_o,
  output ooo_pkg::preg_t                inval_preg_o
);

  import ooo_pkg::*;

  logic is_alu;
  logic accept;
  logic wb_hit1;
  logic wb_hit2;

  // ------------------------------
  // Steering
  // ------------------------------
  assign is_alu       = (disp_op_i.op_class == CLASS_ALU);
  assign disp_ready_o = is_alu ? !alu_full_i : !cmp_full_i;
  assign accept       = disp_valid_i && disp_ready_o;

  assign alu_insert_o = accept && is_alu;
  assign cmp_insert_o = accept && !is_alu;

  // Same function field, read per queue
  assign alu_func_o = alu_op_t'(disp_op_i.func);
  assign cmp_func_o = cmp_cond_t'(disp_op_i.func);

  // ------------------------------
  // Source readiness
  // ------------------------------

  // Writeback in this cycle lands after the entry is written
  assign wb_hit1 = wb_i.valid && (wb_i.preg == disp_op_i.prs1);
  assign wb_hit2 = wb_i.valid && (wb_i.preg == disp_op_i.prs2);

  always_comb begin
    tags_o.prs1 = disp_op_i.prs1;
    tags_o.prs2 = disp_op_i.prs2;
    tags_o.prd  = disp_op_i.prd;
    tags_o.rdy1 = prf_valid_i[disp_op_i.prs1] || wb_hit1;
    tags_o.rdy2 = prf_valid_i[disp_op_i.prs2] || wb_hit2;
  end

  // Destination goes pending until its writeback
  assign inval_valid_o = accept;
  assign inval_preg_o  = disp_op_i.prd;

endmodule

/* hw/phys_regfile.sv */
// Physical register file
`timescale 1ns/1ps

module phys_regfile (
  input  logic                          clk,
  input  logic                          rst_n,

  input  ooo_pkg::preg_t                raddr1_i,
  input  ooo_pkg::preg_t                raddr2_i,
  output ooo_pkg::xlen_t                rdata1_o,
  output ooo_pkg::xlen_t                rdata2_o,

  input  ooo_pkg::wb_t                  wb_i,

  input  logic                          inval_valid_i,
  input  ooo_pkg::preg_t                inval_preg_i,

  output logic [ooo_pkg::NUM_PREGS-1:0] valid_o
);

  import ooo_pkg::*;

  xlen_t                regs_q [NUM_PREGS];
  logic [NUM_PREGS-1:0] valid_q;

  // ------------------------------
  // Read ports
  // ------------------------------
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];
  assign valid_o  = valid_q;

  // ------------------------------
  // Write and valid tracking
  // ------------------------------

  // Each register starts valid, holding its own index
  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= '1;
      for (int i = 0; i < NUM_PREGS; i++) begin
        regs_q[i] <= xlen_t'(i);
      end
    end else begin
      if (wb_i.valid) begin
        regs_q[wb_i.preg]  <= wb_i.value;
        valid_q[wb_i.preg] <= 1'b1;
      end
      // New producer allocated at dispatch
      if (inval_valid_i) begin
        valid_q[inval_preg_i] <= 1'b0;
      end
    end
  end

  // Dispatch never reuses a tag whose writeback is still due
  a_no_inval_wb_clash: assert property (
    @(posedge clk) disable iff (rst_n)
      (inval_valid_i && wb_i.valid) |-> (inval_preg_i != wb_i.preg)
  );

endmodule

/* hw/exec_unit.sv */
// Issue select and execute
`timescale 1ns/1ps

module exec_unit (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               alu_req_valid_i,
  input  ooo_pkg::alu_op_t   alu_func_i,
  input  ooo_pkg::src_tags_t alu_tags_i,
  output logic               alu_grant_o,

  input  logic               cmp_req_valid_i,
  input  ooo_pkg::cmp_cond_t cmp_cond_i,
  input  ooo_pkg::src_tags_t cmp_tags_i,
  output logic               cmp_grant_o,

  output ooo_pkg::preg_t     raddr1_o,
  output ooo_pkg::preg_t     raddr2_o,
  input  ooo_pkg::xlen_t     rdata1_i,
  input  ooo_pkg::xlen_t     rdata2_i,

  output ooo_pkg::wb_t       wb_o
);

  import ooo_pkg::*;

  src_tags_t sel_tags;
  xlen_t     alu_res;
  logic      cmp_res;

  logic      wb_valid_q;
  preg_t     wb_preg_q;
  xlen_t     wb_value_q;

  // ------------------------------
  // Arbitration, ALU first
  // ------------------------------
  assign alu_grant_o = alu_req_valid_i;
  assign cmp_grant_o = cmp_req_valid_i && !alu_req_valid_i;

  assign sel_tags = alu_req_valid_i ? alu_tags_i : cmp_tags_i;
  assign raddr1_o = sel_tags.prs1;
  assign raddr2_o = sel_tags.prs2;

  // ------------------------------
  // Functional units
  // ------------------------------
  always_comb begin
    case (alu_func_i)
      ALU_ADD: alu_res = rdata1_i + rdata2_i;
      ALU_SUB: alu_res = rdata1_i - rdata2_i;
      ALU_AND: alu_res = rdata1_i & rdata2_i;
      default: alu_res = rdata1_i ^ rdata2_i;
    endcase
  end

  always_comb begin
    case (cmp_cond_i)
      CMP_EQ:  cmp_res = (rdata1_i == rdata2_i);
      CMP_NE:  cmp_res = (rdata1_i != rdata2_i);
      CMP_LT:  cmp_res = ($signed(rdata1_i) < $signed(rdata2_i));
      default: cmp_res = (rdata1_i < rdata2_i);
    endcase
  end

  // ------------------------------
  // Writeback register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= alu_grant_o || cmp_grant_o;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_grant_o || cmp_grant_o) begin
      wb_preg_q  <= sel_tags.prd;
      wb_value_q <= alu_grant_o ? alu_res : xlen_t'(cmp_res);
    end
  end

  assign wb_o = '{valid: wb_valid_q, preg: wb_preg_q, value: wb_value_q};

  // A granted entry must have both operands ready
  a_grant_ready: assert property (
    @(posedge clk) disable iff (rst_n)
      (alu_grant_o || cmp_grant_o) |-> (sel_tags.rdy1 && sel_tags.rdy2)
  );

endmodule

/* hw/ooo_core_top.sv */
// Issue and execute core top
`timescale 1ns/1ps

module ooo_core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              disp_valid_i,
  input  ooo_pkg::disp_op_t disp_op_i,
  output logic              disp_ready_o,
  output ooo_pkg::wb_t      wb_o
);

  import ooo_pkg::*;

  // ------------------------------
  // Internal nets
  // ------------------------------
  logic                 alu_insert, cmp_insert;
  alu_op_t              alu_func;
  cmp_cond_t            cmp_func;
  src_tags_t            disp_tags;
  logic                 alu_full, cmp_full;
  logic                 inval_valid;
  preg_t                inval_preg;
  logic [NUM_PREGS-1:0] prf_valid;

  logic                 alu_req_valid, cmp_req_valid;
  alu_op_t              alu_req_func;
  cmp_cond_t            cmp_req_cond;
  src_tags_t            alu_req_tags, cmp_req_tags;
  logic                 alu_grant, cmp_grant;

  preg_t                raddr1, raddr2;
  xlen_t                rdata1, rdata2;
  wb_t                  wb;

  assign wb_o = wb;

  dispatch_unit u_dispatch (
    .disp_valid_i (disp_valid_i),  .disp_op_i    (disp_op_i),
    .disp_ready_o (disp_ready_o),  .alu_full_i   (alu_full),
    .cmp_full_i   (cmp_full),      .prf_valid_i  (prf_valid),
    .wb_i         (wb),            .alu_insert_o (alu_insert),
    .cmp_insert_o (cmp_insert),    .alu_func_o   (alu_func),
    .cmp_func_o   (cmp_func),      .tags_o       (disp_tags),
    .inval_valid_o(inval_valid),   .inval_preg_o (inval_preg)
  );

  // ------------------------------
  // Issue queues
  // ------------------------------
  issue_queue #(.DEPTH(IQ_DEPTH), .payload_t(alu_op_t)) u_alu_iq (
    .clk(clk), .rst_n(rst_n),
    .insert_valid_i(alu_insert), .insert_payload_i(alu_func), .insert_tags_i(disp_tags),
    .full_o(alu_full), .wb_i(wb),
    .req_valid_o(alu_req_valid), .req_payload_o(alu_req_func), .req_tags_o(alu_req_tags),
    .grant_i(alu_grant)
  );

  issue_queue #(.DEPTH(IQ_DEPTH), .payload_t(cmp_cond_t)) u_cmp_iq (
    .clk(clk), .rst_n(rst_n),
    .insert_valid_i(cmp_insert), .insert_payload_i(cmp_func), .insert_tags_i(disp_tags),
    .full_o(cmp_full), .wb_i(wb),
    .req_valid_o(cmp_req_valid), .req_payload_o(cmp_req_cond), .req_tags_o(cmp_req_tags),
    .grant_i(cmp_grant)
  );

  phys_regfile u_prf (
    .clk(clk), .rst_n(rst_n),
    .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .wb_i(wb), .inval_valid_i(inval_valid), .inval_preg_i(inval_preg),
    .valid_o(prf_valid)
  );

  exec_unit u_exec (
    .clk(clk), .rst_n(rst_n),
    .alu_req_valid_i(alu_req_valid), .alu_func_i(alu_req_func),
    .alu_tags_i(alu_req_tags), .alu_grant_o(alu_grant),
    .cmp_req_valid_i(cmp_req_valid), .cmp_cond_i(cmp_req_cond),
    .cmp_tags_i(cmp_req_tags), .cmp_grant_o(cmp_grant),
    .raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .wb_o(wb)
  );

endmodule

/* sim/tb_clock.sv */
// Testbench clock source
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

/* sim/tb_ooo_core.sv */
// Issue and execute core testbench
`timescale 1ns/1ps

module tb_ooo_core;

  import ooo_pkg::*;

  localparam int          CLK_PERIOD_NS  = 40;
  localparam int          DRIVE_DLY      = 2;
  localparam int          TOTAL_OPS      = 150;
  localparam int          OP_CYCLE_BOUND = 20;
  localparam int          WATCHDOG_CYC   = TOTAL_OPS * OP_CYCLE_BOUND + 50;
  localparam logic [15:0] SEED           = 16'd34;

  logic     clk;
  logic     rst_n;
  logic     disp_valid;
  disp_op_t disp_op;
  logic     disp_ready;
  wb_t      wb;

  // Reference model, in-flight operations indexed by prd
  xlen_t       regs_m      [NUM_PREGS];
  int          readers_m   [NUM_PREGS];
  logic        written_m   [NUM_PREGS];
  logic        inflight_v  [NUM_PREGS];
  disp_op_t    inflight_op [NUM_PREGS];
  int          inflight_cnt;
  preg_t       last_prd;
  logic [15:0] lfsr;
  int          err_cnt, check_cnt, wb_cnt, stall_cnt, split_cnt;

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk_o(clk));

  ooo_core_top u_ooo_core_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .disp_valid_i(disp_valid),
    .disp_op_i   (disp_op),
    .disp_ready_o(disp_ready),
    .wb_o        (wb)
  );

  // ------------------------------
  // Random source
  // ------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // ------------------------------
  // Model and stimulus rules
  // ------------------------------
  function automatic xlen_t model_result(disp_op_t op, xlen_t a, xlen_t b);
    if (op.op_class == CLASS_ALU) begin
      case (alu_op_t'(op.func))
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        default: return a ^ b;
      endcase
    end
    case (cmp_cond_t'(op.func))
      CMP_EQ:  return xlen_t'(a == b);
      CMP_NE:  return xlen_t'(a != b);
      CMP_LT:  return xlen_t'($signed(a) < $signed(b));
      default: return xlen_t'(a < b);
    endcase
  endfunction

  // No pending writer, no waiting reader, not one of its own sources
  function automatic logic dest_free(preg_t r, preg_t s1, preg_t s2);
    return !inflight_v[r] && readers_m[r] == 0 && r != s1 && r != s2;
  endfunction

  task automatic pick_untouched(output preg_t r);
    int v;
    r = '0;
    for (int t = 0; t < 64; t++) begin
      draw_bits(PREG_W, v);
      r = preg_t'(v);
      if (!written_m[r]) break;
    end
  endtask

  task automatic pick_dest(input preg_t s1, input preg_t s2, output logic found,
                           output preg_t d);
    int v;
    found = 1'b0;
    d     = '0;
    for (int t = 0; t < 64 && !found; t++) begin
      draw_bits(PREG_W, v);
      if (dest_free(preg_t'(v), s1, s2)) begin
        d     = preg_t'(v);
        found = 1'b1;
      end
    end
  endtask

  // Modes: 1 untouched sources, 2 ALU, 3 mostly compare, 4 chain, 5 ALU chain burst
  task automatic make_op(input int mode, output logic ok, output disp_op_t op);
    int    v;
    preg_t s1;
    preg_t s2;
    preg_t d;
    op = '0;
    draw_bits(2, v);
    if (mode == 2 || mode == 5) begin
      op.op_class = CLASS_ALU;
    end else if (mode == 3) begin
      op.op_class = (v != 0) ? CLASS_CMP : CLASS_ALU;
    end else begin
      op.op_class = op_class_t'(v[0]);
    end
    draw_bits(2, v);
    op.func = v[1:0];
    if (mode == 1) begin
      pick_untouched(s1);
      pick_untouched(s2);
    end else begin
      draw_bits(PREG_W, v);
      s1 = preg_t'(v);
      draw_bits(PREG_W, v);
      s2 = preg_t'(v);
      if (mode >= 4) s1 = last_prd;
    end
    pick_dest(s1, s2, ok, d);
    op.prs1 = s1;
    op.prs2 = s2;
    op.prd  = d;
  endtask

  // ------------------------------
  // Cycle stepping and checks
  // ------------------------------
  task automatic observe_writeback();
    disp_op_t op;
    xlen_t    a;
    xlen_t    b;
    xlen_t    expv;
    if (wb.valid) begin
      wb_cnt++;
      assert (inflight_v[wb.preg]) else begin
        $display("Error at %0t: writeback to p%0d with no operation in flight",
                 $time, wb.preg);
        err_cnt++;
      end
      if (inflight_v[wb.preg]) begin
        op   = inflight_op[wb.preg];
        a    = regs_m[op.prs1];
        b    = regs_m[op.prs2];
        expv = model_result(op, a, b);
        check_cnt++;
        assert (!inflight_v[op.prs1] && !inflight_v[op.prs2]) else begin
          $display("Error at %0t: p%0d wrote back before its producer", $time, op.prd);
          err_cnt++;
        end
        assert (wb.value === expv) else begin
          $display("Fail %0t: p%0d got %h, expected %h", $time, op.prd, wb.value, expv);
          err_cnt++;
        end
        if (op.op_class == CLASS_CMP && op.func[1] && (($signed(a) < $signed(b)) != (a < b)))
          split_cnt++;
        regs_m[op.prd]     = expv;
        inflight_v[op.prd] = 1'b0;
        readers_m[op.prs1]--;
        readers_m[op.prs2]--;
        inflight_cnt--;
      end
    end
  endtask

  // Sample at the falling edge, drive just after the rising edge
  task automatic step_cycle(output logic accepted);
    @(negedge clk);
    observe_writeback();
    accepted = disp_valid && disp_ready;
    if (disp_valid && !disp_ready) stall_cnt++;
    if (accepted) begin
      inflight_op[disp_op.prd] = disp_op;
      inflight_v[disp_op.prd]  = 1'b1;
      written_m[disp_op.prd]   = 1'b1;
      readers_m[disp_op.prs1]++;
      readers_m[disp_op.prs2]++;
      inflight_cnt++;
      last_prd = disp_op.prd;
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic run_test(input int id, input string name, input int n_ops, input int mode);
    int       done_ops;
    int       err0;
    int       wb0;
    int       stall0;
    int       split0;
    logic     ok;
    logic     accepted;
    disp_op_t op;
    done_ops = 0;
    err0     = err_cnt;
    wb0      = wb_cnt;
    stall0   = stall_cnt;
    split0   = split_cnt;
    while (done_ops < n_ops) begin
      make_op(mode, ok, op);
      if (!ok) begin
        disp_valid = 1'b0;
        step_cycle(accepted);
      end else begin
        disp_op    = op;
        disp_valid = 1'b1;
        accepted   = 1'b0;
        while (!accepted) step_cycle(accepted);
        done_ops++;
      end
    end
    disp_valid = 1'b0;
    while (inflight_cnt > 0) step_cycle(accepted);
    assert (wb_cnt - wb0 == n_ops) else begin
      $display("Error: %0d writebacks seen for %0d accepted operations", wb_cnt - wb0, n_ops);
      err_cnt++;
    end
    if (mode == 3) begin
      assert (split_cnt > split0) else begin
        $display("Error: signed and unsigned less-than never disagreed");
        err_cnt++;
      end
    end
    if (mode == 5) begin
      assert (stall_cnt > stall0) else begin
        $display("Error: dispatch was never held off during the burst");
        err_cnt++;
      end
    end
    $display("Test %0d %s: %0d ops, %0d stall cycles, %0d errors",
             id, name, n_ops, stall_cnt - stall0, err_cnt - err0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst_n        = 1'b1;
    disp_valid   = 1'b0;
    disp_op      = '0;
    lfsr         = SEED;
    err_cnt      = 0;
    check_cnt    = 0;
    wb_cnt       = 0;
    stall_cnt    = 0;
    split_cnt    = 0;
    inflight_cnt = 0;
    last_prd     = '0;
    for (int r = 0; r < NUM_PREGS; r++) begin
      regs_m[r]     = xlen_t'(r);
      readers_m[r]  = 0;
      written_m[r]  = 1'b0;
      inflight_v[r] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    @(negedge clk);
    assert (!wb.valid && disp_ready) else begin
      $display("Error at %0t: core not idle after reset", $time);
      err_cnt++;
    end
    @(posedge clk);
    #DRIVE_DLY;
    run_test(1, "reset_values", 10, 1);
    run_test(2, "alu_functions", 40, 2);
    run_test(3, "compare_conditions", 40, 3);
    run_test(4, "dependent_chain", 30, 4);
    run_test(5, "burst_backpressure", 30, 5);
    $display("Summary: 5 tests, %0d checks, %0d lt/ltu splits, %0d errors",
             check_cnt, split_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD_NS);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* verilog.f */
hw/ooo_pkg.sv
hw/issue_queue.sv
hw/dispatch_unit.sv
hw/phys_regfile.sv
hw/exec_unit.sv
hw/ooo_core_top.sv
sim/tb_clock.sv
sim/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_ooo_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ooo_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
